// File: verilog/bist_pkg.sv
package bist_pkg;

    // RAM geometry
    localparam int ADDR_W = 10;
    localparam int DATA_W = 32;

    // State codes carried in an error record
    localparam logic [7:0] ST_WRITE = 8'h01;
    localparam logic [7:0] ST_READ  = 8'h02;

    // Report stream bytes
    localparam logic [7:0] REP_ERR_HDR = 8'hEE;
    localparam logic [7:0] REP_LOOP    = 8'h4C;

    // Header, state, 2 address bytes, 4 expected, 4 actual
    localparam int REP_ERR_LEN = 12;

    // RAM write port
    typedef struct packed {
        logic              en;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } mem_wr_t;

    // RAM read request, data returns one cycle later
    typedef struct packed {
        logic              en;
        logic [ADDR_W-1:0] addr;
    } mem_rd_t;

    // One mismatch found by the read pass
    typedef struct packed {
        logic [7:0]        state;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] expected;
        logic [DATA_W-1:0] actual;
    } err_rec_t;

endpackage

// File: verilog/bram_dp.sv
`timescale 1ns/10ps

module bram_dp (
    input  logic                        clk,
    input  bist_pkg::mem_wr_t           wr,
    input  bist_pkg::mem_rd_t           rd,
    output logic [bist_pkg::DATA_W-1:0] rd_data
);
    import bist_pkg::*;

    localparam int DEPTH = 2 ** ADDR_W;

    logic [DATA_W-1:0] mem [0:DEPTH-1];

    // Synchronous write port
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // Registered read, output holds while idle
    always_ff @(posedge clk) begin
        if (rd.en) begin
            rd_data <= mem[rd.addr];
        end
    end

endmodule

// File: verilog/lfsr_gen.sv
`timescale 1ns/10ps

module lfsr_gen #(
    parameter logic [bist_pkg::DATA_W-1:0] LFSR_POLY = 32'h8000_0803
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        step,
    input  logic                        load,
    input  logic [bist_pkg::DATA_W-1:0] load_value,
    output logic [bist_pkg::DATA_W-1:0] value
);
    import bist_pkg::*;

    logic [DATA_W-1:0] state;
    logic [DATA_W-1:0] next_state;

    // Galois form, shift left and fold the polynomial in on carry out
    always_comb begin
        next_state = {state[DATA_W-2:0], 1'b0};
        if (state[DATA_W-1]) begin
            next_state = next_state ^ LFSR_POLY;
        end
    end

    // Load wins over step
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= load_value;
        end else if (load) begin
            state <= load_value;
        end else if (step) begin
            state <= next_state;
        end
    end

    assign value = state;

endmodule

// File: verilog/ram_tester.sv
`timescale 1ns/10ps

module ram_tester #(
    parameter int                          ADDRESS_STEP = 2,
    parameter int                          MAX_ADDRESS  = 1023,
    parameter logic [bist_pkg::DATA_W-1:0] LFSR_POLY    = 32'h8000_0803,
    parameter logic [bist_pkg::DATA_W-1:0] LFSR_SEED    = 32'h0000_0001
) (
    input  logic                        clk,
    input  logic                        arst_n,
    output bist_pkg::mem_wr_t           wr,
    output bist_pkg::mem_rd_t           rd,
    input  logic [bist_pkg::DATA_W-1:0] rd_data,
    input  logic                        fault_arm,
    input  logic [bist_pkg::ADDR_W-1:0] fault_addr,
    input  logic [bist_pkg::DATA_W-1:0] fault_mask,
    output logic                        err_valid,
    output bist_pkg::err_rec_t          err_rec,
    input  logic                        report_busy,
    output logic                        loop_done
);
    import bist_pkg::*;

    // Highest address on the step grid
    localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(MAX_ADDRESS - MAX_ADDRESS % ADDRESS_STEP);
    localparam logic [ADDR_W-1:0] STEP      = ADDR_W'(ADDRESS_STEP);

    typedef enum logic [2:0] {
        S_IDLE,
        S_WRITE,
        S_READ,
        S_DRAIN,
        S_DONE
    } tester_state_t;

    tester_state_t     state_q;
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] loop_seed;
    logic              last_addr;

    logic [DATA_W-1:0] wr_value;
    logic [DATA_W-1:0] rd_value;
    logic              rd_issue;

    logic              fault_armed;
    logic [ADDR_W-1:0] fault_addr_q;
    logic [DATA_W-1:0] fault_mask_q;
    logic              fault_hit;

    // Compare stage, item whose read data sits on rd_data
    logic              c_valid;
    logic [ADDR_W-1:0] c_addr;
    logic [DATA_W-1:0] c_exp;
    logic              mismatch;

    assign last_addr = (addr_q == LAST_ADDR);
    assign rd_issue  = (state_q == S_READ) && !err_valid && !report_busy;
    assign fault_hit = (state_q == S_WRITE) && fault_armed && (addr_q == fault_addr_q);
    assign mismatch  = c_valid && (rd_data != c_exp);
    assign loop_done = (state_q == S_DONE);

    always_comb begin
        wr.en   = (state_q == S_WRITE);
        wr.addr = addr_q;
        wr.data = fault_hit ? (wr_value ^ fault_mask_q) : wr_value;
        rd.en   = rd_issue;
        rd.addr = addr_q;
    end

    // Write sequence carries on from loop to loop
    lfsr_gen #(
        .LFSR_POLY (LFSR_POLY)
    ) i_lfsr_wr (
        .clk        (clk),
        .arst_n     (arst_n),
        .step       (wr.en),
        .load       (state_q == S_IDLE),
        .load_value (LFSR_SEED),
        .value      (wr_value)
    );

    // Expected sequence replays this loop's seed
    lfsr_gen #(
        .LFSR_POLY (LFSR_POLY)
    ) i_lfsr_rd (
        .clk        (clk),
        .arst_n     (arst_n),
        .step       (rd_issue),
        .load       (wr.en && last_addr),
        .load_value (loop_seed),
        .value      (rd_value)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q   <= S_IDLE;
            addr_q    <= '0;
            loop_seed <= LFSR_SEED;
        end else begin
            case (state_q)
                S_IDLE: begin
                    state_q <= S_WRITE;
                    addr_q  <= '0;
                end
                S_WRITE: begin
                    if (last_addr) begin
                        state_q <= S_READ;
                        addr_q  <= '0;
                    end else begin
                        addr_q <= addr_q + STEP;
                    end
                end
                S_READ: begin
                    if (rd_issue) begin
                        if (last_addr) begin
                            state_q <= S_DRAIN;
                            addr_q  <= '0;
                        end else begin
                            addr_q <= addr_q + STEP;
                        end
                    end
                end
                S_DRAIN: begin
                    // Last compare done and its record gone
                    if (!c_valid && !err_valid && !report_busy) begin
                        state_q <= S_DONE;
                    end
                end
                S_DONE: begin
                    state_q   <= S_WRITE;
                    loop_seed <= wr_value;
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fault_armed <= 1'b0;
        end else if (fault_arm) begin
            fault_armed <= 1'b1;
        end else if (fault_hit) begin
            fault_armed <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fault_arm) begin
            fault_addr_q <= fault_addr;
            fault_mask_q <= fault_mask;
        end
    end

    // A mismatch that finds the record slot full waits here, rd_data holds meanwhile
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            c_valid <= 1'b0;
        end else if (rd_issue) begin
            c_valid <= 1'b1;
        end else if (!mismatch || !err_valid) begin
            c_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_issue) begin
            c_addr <= addr_q;
            c_exp  <= rd_value;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            err_valid <= 1'b0;
        end else if (mismatch && !err_valid) begin
            err_valid <= 1'b1;
        end else if (err_valid && !report_busy) begin
            err_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (mismatch && !err_valid) begin
            err_rec.state    <= ST_READ;
            err_rec.addr     <= c_addr;
            err_rec.expected <= c_exp;
            err_rec.actual   <= rd_data;
        end
    end

endmodule

// File: verilog/error_reporter.sv
`timescale 1ns/10ps

module error_reporter (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               err_valid,
    input  bist_pkg::err_rec_t err_rec,
    input  logic               loop_done,
    output logic               report_busy,
    output logic [7:0]         tx_data,
    output logic               tx_data_ready,
    input  logic               tx_data_accepted
);
    import bist_pkg::*;

    localparam int BUF_W = REP_ERR_LEN * 8;
    localparam int CNT_W = $clog2(REP_ERR_LEN + 1);

    logic [BUF_W-1:0] shift_buf;
    logic [CNT_W-1:0] bytes_left;
    logic             busy;
    logic             take_rec;
    logic             take_loop;
    logic             accept;

    assign take_rec  = err_valid && !busy;
    assign take_loop = loop_done && !busy && !err_valid;
    assign accept    = busy && tx_data_accepted;

    // Control
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy       <= 1'b0;
            bytes_left <= '0;
        end else if (take_rec) begin
            busy       <= 1'b1;
            bytes_left <= CNT_W'(REP_ERR_LEN);
        end else if (take_loop) begin
            busy       <= 1'b1;
            bytes_left <= CNT_W'(1);
        end else if (accept) begin
            bytes_left <= bytes_left - 1'b1;
            if (bytes_left == CNT_W'(1)) begin
                busy <= 1'b0;
            end
        end
    end

    // Byte buffer, most significant byte goes out first
    always_ff @(posedge clk) begin
        if (take_rec) begin
            shift_buf <= {REP_ERR_HDR,
                          err_rec.state,
                          16'(err_rec.addr),
                          err_rec.expected,
                          err_rec.actual};
        end else if (take_loop) begin
            shift_buf <= {REP_LOOP, {(BUF_W - 8){1'b0}}};
        end else if (accept) begin
            shift_buf <= {shift_buf[BUF_W-9:0], 8'h00};
        end
    end

    assign tx_data       = shift_buf[BUF_W-1 -: 8];
    assign tx_data_ready = busy;
    assign report_busy   = busy;

endmodule

// File: verilog/ram_bist_top.sv
`timescale 1ns/10ps

module ram_bist_top #(
    parameter int                          ADDRESS_STEP = 2,
    parameter int                          MAX_ADDRESS  = 1023,
    parameter logic [bist_pkg::DATA_W-1:0] LFSR_POLY    = 32'h8000_0803,
    parameter logic [bist_pkg::DATA_W-1:0] LFSR_SEED    = 32'h0000_0001
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        fault_arm,
    input  logic [bist_pkg::ADDR_W-1:0] fault_addr,
    input  logic [bist_pkg::DATA_W-1:0] fault_mask,
    output logic [7:0]                  tx_data,
    output logic                        tx_data_ready,
    input  logic                        tx_data_accepted
);
    import bist_pkg::*;

    mem_wr_t           wr;
    mem_rd_t           rd;
    logic [DATA_W-1:0] rd_data;
    logic              err_valid;
    err_rec_t          err_rec;
    logic              report_busy;
    logic              loop_done;

    ram_tester #(
        .ADDRESS_STEP (ADDRESS_STEP),
        .MAX_ADDRESS  (MAX_ADDRESS),
        .LFSR_POLY    (LFSR_POLY),
        .LFSR_SEED    (LFSR_SEED)
    ) i_ram_tester (
        .clk         (clk),
        .arst_n      (arst_n),
        .wr          (wr),
        .rd          (rd),
        .rd_data     (rd_data),
        .fault_arm   (fault_arm),
        .fault_addr  (fault_addr),
        .fault_mask  (fault_mask),
        .err_valid   (err_valid),
        .err_rec     (err_rec),
        .report_busy (report_busy),
        .loop_done   (loop_done)
    );

    bram_dp i_bram_dp (
        .clk     (clk),
        .wr      (wr),
        .rd      (rd),
        .rd_data (rd_data)
    );

    error_reporter i_error_reporter (
        .clk              (clk),
        .arst_n           (arst_n),
        .err_valid        (err_valid),
        .err_rec          (err_rec),
        .loop_done        (loop_done),
        .report_busy      (report_busy),
        .tx_data          (tx_data),
        .tx_data_ready    (tx_data_ready),
        .tx_data_accepted (tx_data_accepted)
    );

endmodule

// File: tests/ram_bist_props.sv
`timescale 1ns/10ps

module ram_bist_props (
    input logic       clk,
    input logic       arst_n,
    input logic [7:0] tx_data,
    input logic       tx_data_ready,
    input logic       tx_data_accepted,
    input logic       err_valid,
    input logic       report_busy,
    input logic       wr_en,
    input logic       rd_en,
    input logic       loop_done
);

    // Read pass runs from the first read of a loop up to its loop_done
    logic in_read;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            in_read <= 1'b0;
        end else if (loop_done) begin
            in_read <= 1'b0;
        end else if (rd_en) begin
            in_read <= 1'b1;
        end
    end

    tx_hold: assert property (@(posedge clk) disable iff (!arst_n)
        tx_data_ready && !tx_data_accepted |=> tx_data_ready && $stable(tx_data))
        else $error("tx_data changed before the sink took it");

    // Held while the reporter is busy, handed over and dropped once it is free
    err_hold: assert property (@(posedge clk) disable iff (!arst_n)
        err_valid |=> (err_valid && $past(report_busy))
                      || (!err_valid && !$past(report_busy) && report_busy))
        else $error("error record dropped early or not taken by the reporter");

    no_write_in_read: assert property (@(posedge clk) disable iff (!arst_n)
        in_read |-> !wr_en)
        else $error("RAM write during the read pass");

endmodule

bind ram_bist_top ram_bist_props i_ram_bist_props (
    .clk              (clk),
    .arst_n           (arst_n),
    .tx_data          (tx_data),
    .tx_data_ready    (tx_data_ready),
    .tx_data_accepted (tx_data_accepted),
    .err_valid        (err_valid),
    .report_busy      (report_busy),
    .wr_en            (wr.en),
    .rd_en            (rd.en),
    .loop_done        (loop_done)
);

// File: tests/tb_ram_bist.sv
`timescale 1ns/10ps

module tb_ram_bist;
    import bist_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int MAX_ADDR   = 63;
    localparam int ADDR_STEP  = 2;
    localparam int WORDS      = MAX_ADDR / ADDR_STEP + 1;
    localparam logic [DATA_W-1:0] POLY = 32'h8000_0803;
    localparam logic [DATA_W-1:0] SEED = 32'h0000_0001;
    localparam int MAX_DELAY  = 7;
    localparam int MAX_SKIPS  = 4;
    // Worst loop, write and read passes plus one report and a marker
    localparam int LOOP_LEN   = 2 * WORDS + 4 + REP_ERR_LEN + 1;
    localparam int N_TESTS    = 6;
    localparam int TIMEOUT_NS = N_TESTS * MAX_SKIPS * LOOP_LEN * (MAX_DELAY + 1) * CLK_PERIOD * 2;

    logic              clk;
    logic              arst_n;
    logic              fault_arm;
    logic [ADDR_W-1:0] fault_addr;
    logic [DATA_W-1:0] fault_mask;
    logic [7:0]        tx_data;
    logic              tx_data_ready;
    logic              tx_data_accepted;

    logic [7:0] rx_q [$];
    int errors;
    int checks;
    int tests_failed;
    int loops_done;
    int wait_left;
    int seed = 74;
    bit slow_sink;

    ram_bist_top #(
        .ADDRESS_STEP (ADDR_STEP),
        .MAX_ADDRESS  (MAX_ADDR),
        .LFSR_POLY    (POLY),
        .LFSR_SEED    (SEED)
    ) i_ram_bist_top (
        .clk              (clk),
        .arst_n           (arst_n),
        .fault_arm        (fault_arm),
        .fault_addr       (fault_addr),
        .fault_mask       (fault_mask),
        .tx_data          (tx_data),
        .tx_data_ready    (tx_data_ready),
        .tx_data_accepted (tx_data_accepted)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Byte sink, takes a byte after 0 cycles or a random wait
    initial begin
        tx_data_accepted = 1'b0;
        wait_left = 0;
        forever begin
            @(negedge clk);
            tx_data_accepted = 1'b0;
            if (arst_n && tx_data_ready) begin
                if (wait_left == 0) begin
                    tx_data_accepted = 1'b1;
                    rx_q.push_back(tx_data);
                    wait_left = slow_sink ? $unsigned($random(seed)) % (MAX_DELAY + 1) : 0;
                end else begin
                    wait_left--;
                end
            end
        end
    end

    function automatic logic [DATA_W-1:0] lfsr_next(input logic [DATA_W-1:0] s);
        logic [DATA_W-1:0] n;
        n = {s[DATA_W-2:0], 1'b0};
        if (s[DATA_W-1]) begin
            n = n ^ POLY;
        end
        return n;
    endfunction

    // Word written at addr in loop number loop_idx
    function automatic logic [DATA_W-1:0] lfsr_word(input int loop_idx, input int addr);
        logic [DATA_W-1:0] s;
        s = SEED;
        for (int i = 0; i < loop_idx * WORDS + addr / ADDR_STEP; i++) begin
            s = lfsr_next(s);
        end
        return s;
    endfunction

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_rec(input string name, input err_rec_t exp, input err_rec_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic pop_byte(output logic [7:0] b);
        while (rx_q.size() == 0) begin
            @(posedge clk);
        end
        b = rx_q.pop_front();
    endtask

    task automatic expect_loop();
        logic [7:0] b;
        pop_byte(b);
        check_byte("tx_data", REP_LOOP, b);
        loops_done++;
    endtask

    // Skips clean loops until the report shows up, then wants its marker
    task automatic expect_report(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] mask);
        logic [7:0] bytes [0:REP_ERR_LEN-1];
        err_rec_t   exp_rec;
        err_rec_t   act_rec;
        int         skips;
        skips = 0;
        pop_byte(bytes[0]);
        while (bytes[0] === REP_LOOP && skips < MAX_SKIPS) begin
            loops_done++;
            skips++;
            pop_byte(bytes[0]);
        end
        check_byte("tx_data", REP_ERR_HDR, bytes[0]);
        if (bytes[0] !== REP_ERR_HDR) begin
            return;
        end
        for (int i = 1; i < REP_ERR_LEN; i++) begin
            pop_byte(bytes[i]);
        end
        exp_rec.state    = ST_READ;
        exp_rec.addr     = addr;
        exp_rec.expected = lfsr_word(loops_done, addr);
        exp_rec.actual   = exp_rec.expected ^ mask;
        act_rec.state    = bytes[1];
        act_rec.addr     = ADDR_W'({bytes[2], bytes[3]});
        act_rec.expected = {bytes[4], bytes[5], bytes[6], bytes[7]};
        act_rec.actual   = {bytes[8], bytes[9], bytes[10], bytes[11]};
        check_byte("addr_hi", 8'(exp_rec.addr >> 8), bytes[2]);
        check_rec("err_rec", exp_rec, act_rec);
        expect_loop();
    endtask

    task automatic arm_fault(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] mask);
        @(negedge clk);
        fault_arm  = 1'b1;
        fault_addr = addr;
        fault_mask = mask;
        @(negedge clk);
        fault_arm = 1'b0;
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errs_before);
        end
    endtask

    task automatic reset_quiet();
        int errs;
        errs = errors;
        arst_n = 1'b0;
        repeat (5) begin
            @(negedge clk);
            check_bit("tx_data_ready", 1'b0, tx_data_ready);
        end
        arst_n = 1'b1;
        @(negedge clk);
        check_bit("tx_data_ready", 1'b0, tx_data_ready);
        if (rx_q.size() != 0) begin
            errors++;
            $display("A byte arrived during reset or on the first cycle after it");
        end
        end_test("reset_quiet", errs);
    endtask

    task automatic clean_loops();
        int errs;
        errs = errors;
        expect_loop();
        expect_loop();
        end_test("clean_loops", errs);
    endtask

    task automatic single_fault();
        int errs;
        errs = errors;
        arm_fault(10, 32'h0000_0100);
        expect_report(10, 32'h0000_0100);
        // Fault is used up, the next loop is clean
        expect_loop();
        end_test("single_fault", errs);
    endtask

    task automatic slow_sink_fault();
        int errs;
        errs = errors;
        slow_sink = 1'b1;
        arm_fault(10, 32'h0000_0100);
        expect_report(10, 32'h0000_0100);
        slow_sink = 1'b0;
        end_test("slow_sink_fault", errs);
    endtask

    task automatic two_faults();
        int errs;
        errs = errors;
        arm_fault(60, 32'hFFFF_0000);
        expect_report(60, 32'hFFFF_0000);
        arm_fault(4, 32'h0000_0001);
        expect_report(4, 32'h0000_0001);
        end_test("two_faults", errs);
    endtask

    task automatic off_grid_fault();
        int errs;
        errs = errors;
        arm_fault(11, 32'h8000_0000);
        expect_loop();
        expect_loop();
        end_test("off_grid_fault", errs);
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout, the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        clk        = 1'b0;
        arst_n     = 1'b0;
        fault_arm  = 1'b0;
        fault_addr = '0;
        fault_mask = '0;
        slow_sink  = 1'b0;
        reset_quiet();
        clean_loops();
        single_fault();
        slow_sink_fault();
        two_faults();
        off_grid_fault();
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 N_TESTS, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
verilog/bist_pkg.sv
verilog/bram_dp.sv
verilog/lfsr_gen.sv
verilog/ram_tester.sv
verilog/error_reporter.sv
verilog/ram_bist_top.sv
tests/ram_bist_props.sv
tests/tb_ram_bist.sv

// File: Bender.yml
package:
  name: ram_bist

sources:
  # Design, package first
  - files:
      - verilog/bist_pkg.sv
      - verilog/bram_dp.sv
      - verilog/lfsr_gen.sv
      - verilog/ram_tester.sv
      - verilog/error_reporter.sv
      - verilog/ram_bist_top.sv

  # Testbench and bound assertions
  - target: test
    files:
      - tests/ram_bist_props.sv
      - tests/tb_ram_bist.sv
